/* src/soc_bus_pkg.sv */
package soc_bus_pkg;

  // --------------------
  // AHB-Lite widths and codes
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Transfer is valid whenever bit 1 is set
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic HRESP_OKAY = 1'b0;

  // --------------------
  // Address map
  // --------------------
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [3:0] REGION_RAM  = 4'd2;
  localparam logic [3:0] REGION_UART = 4'd4;
  localparam logic [3:0] REGION_GPIO = 4'd5;

  // Slave indices, 3 is the default slave
  localparam int NUM_SLAVES = 3;
  localparam logic [1:0] SLV_RAM     = 2'd0;
  localparam logic [1:0] SLV_UART    = 2'd1;
  localparam logic [1:0] SLV_GPIO    = 2'd2;
  localparam logic [1:0] SLV_DEFAULT = 2'd3;

  // Word address bits, 4 KB RAM
  localparam int RAM_ADDR_W = 10;

endpackage

/* src/soc_periph_pkg.sv */
package soc_periph_pkg;

  // Register select inside a peripheral
  localparam int REG_OFS_LSB = 2;
  localparam int REG_OFS_MSB = 3;

  localparam logic [1:0] OFS_DATA   = 2'd0;
  localparam logic [1:0] OFS_STATUS = 2'd1;

  // GPIO widths
  localparam int LED_W = 8;
  localparam int KEY_W = 4;

  // --------------------
  // UART
  // --------------------
  localparam int UART_DATA_W = 8;
  // Short bit period for simulation
  localparam int UART_BIT_CYCLES = 16;

  // Status register bits
  localparam int STAT_TX_BUSY  = 0;
  localparam int STAT_RX_VALID = 1;

endpackage

/* src/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
  parameter int BIT_CYCLES = soc_periph_pkg::UART_BIT_CYCLES
) (
  input  logic clk,
  input  logic RSTn,
  input  logic tx_start,
  input  logic [soc_periph_pkg::UART_DATA_W-1:0] tx_data,
  output logic tx_busy,
  output logic txd
);

  localparam int CNT_W = $clog2(BIT_CYCLES);
  // Start, data and stop bit
  localparam int FRAME_BITS = soc_periph_pkg::UART_DATA_W + 2;

  logic [CNT_W-1:0] cnt;
  logic [3:0] bit_idx;
  logic [FRAME_BITS-1:0] frame;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      tx_busy <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      // Line idles high
      frame   <= '1;
    end else if (tx_start) begin
      tx_busy <= 1'b1;
      cnt     <= '0;
      bit_idx <= '0;
      frame   <= {1'b1, tx_data, 1'b0};
    end else if (tx_busy) begin
      if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
        cnt   <= '0;
        // LSB first, ones shift in behind the stop bit
        frame <= {1'b1, frame[FRAME_BITS-1:1]};
        if (bit_idx == 4'(FRAME_BITS - 1)) begin
          tx_busy <= 1'b0;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign txd = frame[0];

  a_no_start_busy: assert property (@(posedge clk) disable iff (!RSTn)
    tx_start |-> !tx_busy);

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
  parameter int BIT_CYCLES = soc_periph_pkg::UART_BIT_CYCLES
) (
  input  logic clk,
  input  logic RSTn,
  input  logic rxd,
  output logic [soc_periph_pkg::UART_DATA_W-1:0] rx_data,
  output logic rx_done
);

  localparam int CNT_W = $clog2(BIT_CYCLES);
  localparam int MID = BIT_CYCLES / 2;
  // Index of the stop bit, start bit is 0
  localparam int STOP = soc_periph_pkg::UART_DATA_W + 1;

  logic rx_s1;
  logic rx_s2;
  logic rx_prev;
  logic busy;
  logic sample;
  logic [CNT_W-1:0] cnt;
  logic [3:0] bit_idx;
  logic [soc_periph_pkg::UART_DATA_W-1:0] shreg;

  // Mid-bit sample point
  assign sample = busy && cnt == CNT_W'(MID);

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
      busy    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_s1   <= rxd;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
      rx_done <= 1'b0;
      if (!busy) begin
        // Start edge
        if (rx_prev && !rx_s2) begin
          busy    <= 1'b1;
          cnt     <= '0;
          bit_idx <= '0;
        end
      end else begin
        cnt <= (cnt == CNT_W'(BIT_CYCLES - 1)) ? '0 : cnt + 1'b1;
        if (cnt == CNT_W'(BIT_CYCLES - 1)) begin
          bit_idx <= bit_idx + 1'b1;
        end
        if (sample && bit_idx == 4'd0 && rx_s2) begin
          // Glitch, not a start bit
          busy <= 1'b0;
        end else if (sample && bit_idx == 4'(STOP)) begin
          busy    <= 1'b0;
          // Framing error drops the byte
          rx_done <= rx_s2;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample && bit_idx != 4'd0 && bit_idx != 4'(STOP)) begin
      shreg <= {rx_s2, shreg[soc_periph_pkg::UART_DATA_W-1:1]};
    end
    if (sample && bit_idx == 4'(STOP) && rx_s2) begin
      rx_data <= shreg;
    end
  end

endmodule

/* src/ahb_interconnect.sv */
`timescale 1ns/1ns

module ahb_interconnect (
  input  logic clk,
  input  logic RSTn,
  input  logic [soc_bus_pkg::ADDR_W-1:0] haddr,
  input  logic [1:0] htrans,
  output logic hready,
  output logic [soc_bus_pkg::DATA_W-1:0] hrdata,
  output logic hresp,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0] hsel,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0][soc_bus_pkg::DATA_W-1:0] s_hrdata,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0] s_hreadyout
);

  logic [soc_bus_pkg::REGION_MSB-soc_bus_pkg::REGION_LSB:0] region;
  // Address phase decode
  logic [1:0] dec_idx;
  // Slave owning the current data phase
  logic [1:0] sel_q;

  assign region = haddr[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB];

  // --------------------
  // Address phase
  // --------------------
  always_comb begin
    dec_idx = soc_bus_pkg::SLV_DEFAULT;
    if (htrans[1]) begin
      case (region)
        soc_bus_pkg::REGION_RAM:  dec_idx = soc_bus_pkg::SLV_RAM;
        soc_bus_pkg::REGION_UART: dec_idx = soc_bus_pkg::SLV_UART;
        soc_bus_pkg::REGION_GPIO: dec_idx = soc_bus_pkg::SLV_GPIO;
        // Unmapped goes to the default slave
        default:                  dec_idx = soc_bus_pkg::SLV_DEFAULT;
      endcase
    end
  end

  // One select line per mapped region and none for unmapped addresses
  assign hsel[soc_bus_pkg::SLV_RAM]  = htrans[1] && region == soc_bus_pkg::REGION_RAM;
  assign hsel[soc_bus_pkg::SLV_UART] = htrans[1] && region == soc_bus_pkg::REGION_UART;
  assign hsel[soc_bus_pkg::SLV_GPIO] = htrans[1] && region == soc_bus_pkg::REGION_GPIO;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      sel_q <= soc_bus_pkg::SLV_DEFAULT;
    end else if (hready) begin
      sel_q <= dec_idx;
    end
  end

  // --------------------
  // Data phase
  // --------------------
  // Default slave reads zero and never stalls
  always_comb begin
    hrdata = '0;
    hready = 1'b1;
    if (sel_q != soc_bus_pkg::SLV_DEFAULT) begin
      hrdata = s_hrdata[sel_q];
      hready = s_hreadyout[sel_q];
    end
  end

  // No slave reports errors
  assign hresp = soc_bus_pkg::HRESP_OKAY;

  // Overlapping regions in the address map would select two slaves
  a_hsel_onehot: assert property (@(posedge clk) disable iff (!RSTn) $onehot0(hsel));

endmodule

/* src/ahb_block_ram.sv */
`timescale 1ns/1ns

module ahb_block_ram #(
  parameter int ADDR_W = soc_bus_pkg::RAM_ADDR_W
) (
  input  logic clk,
  input  logic RSTn,
  input  logic hsel,
  input  logic [soc_bus_pkg::ADDR_W-1:0] haddr,
  input  logic [1:0] htrans,
  input  logic [2:0] hsize,
  input  logic hwrite,
  input  logic [soc_bus_pkg::DATA_W-1:0] hwdata,
  input  logic hready,
  output logic [soc_bus_pkg::DATA_W-1:0] hrdata,
  output logic hreadyout
);

  logic [soc_bus_pkg::DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

  logic acc;
  logic rd_acc;
  logic [ADDR_W-1:0] word;
  logic [3:0] lane_mask;
  // Write waiting for its data phase
  logic wr_pend;
  logic [ADDR_W-1:0] wr_addr;
  logic [3:0] wr_mask;
  // Read data and write-to-read bypass
  logic [soc_bus_pkg::DATA_W-1:0] rd_q;
  logic [soc_bus_pkg::DATA_W-1:0] byp_data;
  logic [3:0] byp_mask;

  assign acc = hsel && htrans[1] && hready;
  assign rd_acc = acc && !hwrite;
  assign word = haddr[ADDR_W+1:2];

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      soc_bus_pkg::HSIZE_BYTE: lane_mask = 4'b0001 << haddr[1:0];
      soc_bus_pkg::HSIZE_HALF: lane_mask = haddr[1] ? 4'b1100 : 4'b0011;
      default:                 lane_mask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_pend  <= 1'b0;
      byp_mask <= '0;
    end else begin
      if (hready) begin
        wr_pend <= acc && hwrite;
      end
      // Lanes still in flight to the word being read
      if (rd_acc) begin
        byp_mask <= (wr_pend && wr_addr == word) ? wr_mask : 4'b0000;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc && hwrite) begin
      wr_addr <= word;
      wr_mask <= lane_mask;
    end
    // Write lands at the end of its data phase
    if (wr_pend && hready) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_mask[i]) begin
          mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
        end
      end
    end
    if (rd_acc) begin
      rd_q     <= mem[word];
      byp_data <= hwdata;
    end
  end

  // Merge bypassed lanes over the array read
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      hrdata[8*i +: 8] = byp_mask[i] ? byp_data[8*i +: 8] : rd_q[8*i +: 8];
    end
  end

  assign hreadyout = 1'b1;

  a_size_legal: assert property (@(posedge clk) disable iff (!RSTn)
    acc |-> hsize <= soc_bus_pkg::HSIZE_WORD);

endmodule

/* src/ahb_gpio.sv */
`timescale 1ns/1ns

module ahb_gpio (
  input  logic clk,
  input  logic RSTn,
  input  logic hsel,
  input  logic [soc_bus_pkg::ADDR_W-1:0] haddr,
  input  logic [1:0] htrans,
  input  logic hwrite,
  input  logic [soc_bus_pkg::DATA_W-1:0] hwdata,
  input  logic hready,
  output logic [soc_bus_pkg::DATA_W-1:0] hrdata,
  output logic hreadyout,
  input  logic [soc_periph_pkg::KEY_W-1:0] keys,
  output logic [soc_periph_pkg::LED_W-1:0] led,
  output logic [soc_periph_pkg::KEY_W-1:0] key_irq
);

  logic wr_q;
  logic [1:0] ofs_q;
  // Key synchroniser and previous level
  logic [soc_periph_pkg::KEY_W-1:0] key_s1;
  logic [soc_periph_pkg::KEY_W-1:0] key_s2;
  logic [soc_periph_pkg::KEY_W-1:0] key_d;
  logic [soc_periph_pkg::KEY_W-1:0] key_fall;
  logic [soc_periph_pkg::KEY_W-1:0] pend;
  logic [soc_periph_pkg::KEY_W-1:0] pend_clr;

  // Keys are active low, a press is a falling level
  assign key_fall = key_d & ~key_s2;

  // Write-one-to-clear on the status register
  assign pend_clr = (wr_q && ofs_q == soc_periph_pkg::OFS_STATUS) ?
                    hwdata[soc_periph_pkg::KEY_W-1:0] : '0;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_q    <= 1'b0;
      ofs_q   <= '0;
      led     <= '0;
      key_s1  <= '1;
      key_s2  <= '1;
      key_d   <= '1;
      key_irq <= '0;
      pend    <= '0;
    end else begin
      if (hready) begin
        wr_q  <= hsel && htrans[1] && hwrite;
        ofs_q <= haddr[soc_periph_pkg::REG_OFS_MSB:soc_periph_pkg::REG_OFS_LSB];
      end
      if (wr_q && ofs_q == soc_periph_pkg::OFS_DATA) begin
        led <= hwdata[soc_periph_pkg::LED_W-1:0];
      end
      key_s1  <= keys;
      key_s2  <= key_s1;
      key_d   <= key_s2;
      key_irq <= key_fall;
      // New press wins over a clear
      pend    <= (pend & ~pend_clr) | key_fall;
    end
  end

  always_comb begin
    hrdata = '0;
    case (ofs_q)
      soc_periph_pkg::OFS_DATA:   hrdata[soc_periph_pkg::LED_W-1:0] = led;
      soc_periph_pkg::OFS_STATUS: hrdata[soc_periph_pkg::KEY_W-1:0] = pend;
      default:                    hrdata = '0;
    endcase
  end

  assign hreadyout = 1'b1;

endmodule

/* src/ahb_uart.sv */
`timescale 1ns/1ns

module ahb_uart (
  input  logic clk,
  input  logic RSTn,
  input  logic hsel,
  input  logic [soc_bus_pkg::ADDR_W-1:0] haddr,
  input  logic [1:0] htrans,
  input  logic hwrite,
  input  logic [soc_bus_pkg::DATA_W-1:0] hwdata,
  input  logic hready,
  output logic [soc_bus_pkg::DATA_W-1:0] hrdata,
  output logic hreadyout,
  input  logic rxd,
  output logic txd,
  output logic uart_irq
);

  logic wr_q;
  logic rd_q;
  logic [1:0] ofs_q;
  logic data_wr;
  logic tx_start;
  logic tx_busy;
  logic rx_done;
  logic [soc_periph_pkg::UART_DATA_W-1:0] rx_data;
  logic rx_valid;

  // --------------------
  // Register access
  // --------------------
  // Data phase state holds while the bus is stalled
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      ofs_q <= '0;
    end else if (hready) begin
      wr_q  <= hsel && htrans[1] && hwrite;
      rd_q  <= hsel && htrans[1] && !hwrite;
      ofs_q <= haddr[soc_periph_pkg::REG_OFS_MSB:soc_periph_pkg::REG_OFS_LSB];
    end
  end

  // Data write stalls until the transmitter is free
  assign data_wr   = wr_q && ofs_q == soc_periph_pkg::OFS_DATA;
  assign hreadyout = !(data_wr && tx_busy);
  assign tx_start  = data_wr && !tx_busy;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rx_valid <= 1'b0;
      uart_irq <= 1'b0;
    end else begin
      uart_irq <= rx_done;
      if (rx_done) begin
        rx_valid <= 1'b1;
      end else if (rd_q && hready && ofs_q == soc_periph_pkg::OFS_DATA) begin
        rx_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    hrdata = '0;
    case (ofs_q)
      soc_periph_pkg::OFS_DATA: hrdata[soc_periph_pkg::UART_DATA_W-1:0] = rx_data;
      soc_periph_pkg::OFS_STATUS: begin
        hrdata[soc_periph_pkg::STAT_TX_BUSY]  = tx_busy;
        hrdata[soc_periph_pkg::STAT_RX_VALID] = rx_valid;
      end
      default: hrdata = '0;
    endcase
  end

  // --------------------
  // Line side
  // --------------------
  uart_tx u_tx (
    .clk      (clk),
    .RSTn     (RSTn),
    .tx_start (tx_start),
    .tx_data  (hwdata[soc_periph_pkg::UART_DATA_W-1:0]),
    .tx_busy  (tx_busy),
    .txd      (txd)
  );

  uart_rx u_rx (
    .clk     (clk),
    .RSTn    (RSTn),
    .rxd     (rxd),
    .rx_data (rx_data),
    .rx_done (rx_done)
  );

endmodule

/* src/periph_soc.sv */
`timescale 1ns/1ns

module periph_soc (
  input  logic clk,
  input  logic RSTn,
  // AHB-Lite master port
  input  logic [soc_bus_pkg::ADDR_W-1:0] haddr,
  input  logic [soc_bus_pkg::DATA_W-1:0] hwdata,
  input  logic [1:0] htrans,
  input  logic [2:0] hsize,
  input  logic hwrite,
  output logic [soc_bus_pkg::DATA_W-1:0] hrdata,
  output logic hready,
  output logic hresp,
  // UART line
  input  logic rxd,
  output logic txd,
  // GPIO
  input  logic [soc_periph_pkg::KEY_W-1:0] keys,
  output logic [soc_periph_pkg::LED_W-1:0] led,
  output logic [soc_periph_pkg::KEY_W-1:0] key_irq,
  output logic uart_irq
);

  logic ram_hsel;
  logic uart_hsel;
  logic gpio_hsel;
  logic [soc_bus_pkg::DATA_W-1:0] ram_hrdata;
  logic [soc_bus_pkg::DATA_W-1:0] uart_hrdata;
  logic [soc_bus_pkg::DATA_W-1:0] gpio_hrdata;
  logic ram_hreadyout;
  logic uart_hreadyout;
  logic gpio_hreadyout;

  // --------------------
  // Interconnect
  // --------------------
  // Slave order is RAM, UART, GPIO from bit 0 up
  ahb_interconnect u_ic (
    .clk         (clk),
    .RSTn        (RSTn),
    .haddr       (haddr),
    .htrans      (htrans),
    .hready      (hready),
    .hrdata      (hrdata),
    .hresp       (hresp),
    .hsel        ({gpio_hsel, uart_hsel, ram_hsel}),
    .s_hrdata    ({gpio_hrdata, uart_hrdata, ram_hrdata}),
    .s_hreadyout ({gpio_hreadyout, uart_hreadyout, ram_hreadyout})
  );

  // --------------------
  // Slaves
  // --------------------
  ahb_block_ram u_ram (
    .clk       (clk),
    .RSTn      (RSTn),
    .hsel      (ram_hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsize     (hsize),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (ram_hrdata),
    .hreadyout (ram_hreadyout)
  );

  ahb_uart u_uart (
    .clk       (clk),
    .RSTn      (RSTn),
    .hsel      (uart_hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (uart_hrdata),
    .hreadyout (uart_hreadyout),
    .rxd       (rxd),
    .txd       (txd),
    .uart_irq  (uart_irq)
  );

  ahb_gpio u_gpio (
    .clk       (clk),
    .RSTn      (RSTn),
    .hsel      (gpio_hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (gpio_hrdata),
    .hreadyout (gpio_hreadyout),
    .keys      (keys),
    .led       (led),
    .key_irq   (key_irq)
  );

endmodule

/* test/tb_periph_soc.sv */
`timescale 1ns/1ns

module tb_periph_soc;

  // Longest UART stall is about one frame, 160 cycles
  localparam int TIMEOUT = 400;
  localparam int POLL_LIMIT = 500;
  localparam logic [31:0] UART_DATA = 32'h4000_0000;
  localparam logic [31:0] UART_STAT = 32'h4000_0004;
  localparam logic [31:0] GPIO_LED  = 32'h5000_0000;
  localparam logic [31:0] RAM_BASE  = 32'h2000_0200;

  logic clk;
  logic RSTn;
  logic [soc_bus_pkg::ADDR_W-1:0] haddr;
  logic [soc_bus_pkg::DATA_W-1:0] hwdata;
  logic [1:0] htrans;
  logic [2:0] hsize;
  logic hwrite;
  logic [soc_bus_pkg::DATA_W-1:0] hrdata;
  logic hready;
  logic hresp;
  // Loopback line, txd feeds rxd
  wire txd;
  logic [soc_periph_pkg::KEY_W-1:0] keys;
  logic [soc_periph_pkg::LED_W-1:0] led;
  logic [soc_periph_pkg::KEY_W-1:0] key_irq;
  logic uart_irq;

  logic [31:0] lfsr_state;
  int pass_cnt;
  int fail_cnt;
  int test_errs;
  int irq_cnt;
  logic timed_out;
  string test_name;

  always #20 clk = ~clk;

  periph_soc dut0 (
    .clk      (clk),
    .RSTn     (RSTn),
    .haddr    (haddr),
    .hwdata   (hwdata),
    .htrans   (htrans),
    .hsize    (hsize),
    .hwrite   (hwrite),
    .hrdata   (hrdata),
    .hready   (hready),
    .hresp    (hresp),
    .rxd      (txd),
    .txd      (txd),
    .keys     (keys),
    .led      (led),
    .key_irq  (key_irq),
    .uart_irq (uart_irq)
  );

  // Registered pulse, stable at the falling edge
  always @(negedge clk) begin
    if (uart_irq) begin
      irq_cnt++;
    end
  end

  // --------------------
  // Reporting
  // --------------------
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] v;
    logic fb;
    v = '0;
    // Taps 32, 22, 2, 1
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d error(s)", test_name, test_errs);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_run();
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic timeout(input string what);
    $display("Timeout in test %s: %s", test_name, what);
    timed_out = 1'b1;
    fail_cnt++;
    finish_run();
  endtask

  // --------------------
  // Bus tasks
  // --------------------
  // Entered and left at a falling edge
  task automatic wait_ready(input string what, output logic stalled);
    int n;
    n = 0;
    stalled = 1'b0;
    while (!hready && n < TIMEOUT) begin
      stalled = 1'b1;
      @(negedge clk);
      n++;
    end
    if (!hready) begin
      timeout(what);
    end
  endtask

  // Returns with the data phase about to end, so the next call pipelines
  task automatic bus_xfer(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic stalled);
    logic st;
    haddr  = addr;
    hsize  = size;
    hwrite = wr;
    htrans = soc_bus_pkg::HTRANS_NONSEQ;
    wait_ready("hready stayed low before the address phase", st);
    @(negedge clk);
    htrans = soc_bus_pkg::HTRANS_IDLE;
    if (wr) begin
      hwdata = wdata;
    end
    wait_ready("hready stayed low in the data phase", stalled);
    rdata = hrdata;
    // OKAY expected on every transfer
    check_value("hresp", 32'd0, {31'b0, hresp});
  endtask

  task automatic bus_write(input logic [2:0] size, input logic [31:0] addr,
                           input logic [31:0] data);
    logic [31:0] rd;
    logic st;
    bus_xfer(1'b1, size, addr, data, rd, st);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    logic st;
    bus_xfer(1'b0, soc_bus_pkg::HSIZE_WORD, addr, 32'd0, data, st);
  endtask

  // Lets the last data phase finish
  task automatic idle_bus();
    htrans = soc_bus_pkg::HTRANS_IDLE;
    @(negedge clk);
  endtask

  task automatic poll_rx_valid();
    logic [31:0] st;
    int n;
    n = 0;
    st = '0;
    while (!st[soc_periph_pkg::STAT_RX_VALID] && n < POLL_LIMIT) begin
      bus_read(UART_STAT, st);
      n++;
    end
    if (!st[soc_periph_pkg::STAT_RX_VALID]) begin
      timeout("UART status never showed rx valid");
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_test();
    begin_test("reset values");
    check_value("led", 32'd0, {24'b0, led});
    check_value("hready", 32'd1, {31'b0, hready});
    check_value("txd", 32'd1, {31'b0, txd});
    check_value("key_irq", 32'd0, {28'b0, key_irq});
    check_value("uart_irq", 32'd0, {31'b0, uart_irq});
    end_test();
  endtask

  task automatic ram_test();
    logic [31:0] words [8];
    logic [31:0] got;
    begin_test("ram random words");
    for (int i = 0; i < 8; i++) begin
      words[i] = lfsr_take(32);
      bus_write(soc_bus_pkg::HSIZE_WORD, RAM_BASE + 32'(4 * i), words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(RAM_BASE + 32'(4 * i), got);
      check_value($sformatf("word %0d", i), words[i], got);
    end
    idle_bus();
    end_test();
  endtask

  task automatic led_test();
    logic [31:0] r;
    logic [31:0] got;
    r = lfsr_take(8);
    begin_test("gpio led");
    bus_write(soc_bus_pkg::HSIZE_WORD, GPIO_LED, {24'b0, r[7:0]});
    // led follows one cycle after the data phase
    idle_bus();
    check_value("led pins", {24'b0, r[7:0]}, {24'b0, led});
    bus_read(GPIO_LED, got);
    check_value("led register", {24'b0, r[7:0]}, got);
    idle_bus();
    end_test();
  endtask

  // One line per case, see the header of the file
  task automatic run_cases();
    int fd;
    int n;
    int cnt;
    string line;
    logic [7:0] op;
    logic [2:0] size;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] got;
    logic [3:0] seen;
    fd = $fopen("test/bus_cases.txt", "r");
    if (fd == 0) begin
      begin_test("case file");
      $display("Could not open the case file test/bus_cases.txt");
      test_errs++;
      end_test();
    end else begin
      n = 0;
      while ($fgets(line, fd) != 0) begin
        cnt = $sscanf(line, "%c %h %h %h %h", op, size, addr, data, exp);
        if (cnt == 5 && op != "#") begin
          n++;
          begin_test($sformatf("case %0d %c %h", n, op, addr));
          case (op)
            "W": bus_write(size, addr, data);
            "R": begin
              bus_read(addr, got);
              check_value("read data", exp, got);
            end
            "K": begin
              idle_bus();
              keys = data[3:0];
              seen = '0;
              // Pulse is due 3 cycles after the key changes
              repeat (8) begin
                @(negedge clk);
                seen = seen | key_irq;
              end
              check_value("key_irq", exp, {28'b0, seen});
            end
            default: begin
              $display("Unknown operation %c in case %0d", op, n);
              test_errs++;
            end
          endcase
          end_test();
        end
      end
      $fclose(fd);
    end
    idle_bus();
  endtask

  task automatic uart_test();
    logic [31:0] r;
    logic [31:0] got;
    logic st;
    r = lfsr_take(16);
    begin_test("uart loopback");
    bus_write(soc_bus_pkg::HSIZE_WORD, UART_DATA, {24'b0, r[7:0]});
    // Transmitter busy, so this one stalls
    bus_xfer(1'b1, soc_bus_pkg::HSIZE_WORD, UART_DATA, {24'b0, r[15:8]}, got, st);
    check_value("stall on busy write", 32'd1, {31'b0, st});
    poll_rx_valid();
    bus_read(UART_DATA, got);
    check_value("first byte", {24'b0, r[7:0]}, got);
    bus_read(UART_STAT, got);
    check_value("rx valid after read", 32'd0, {31'b0, got[soc_periph_pkg::STAT_RX_VALID]});
    poll_rx_valid();
    bus_read(UART_DATA, got);
    check_value("second byte", {24'b0, r[15:8]}, got);
    bus_read(UART_STAT, got);
    check_value("rx valid after read", 32'd0, {31'b0, got[soc_periph_pkg::STAT_RX_VALID]});
    idle_bus();
    check_value("uart_irq pulses", 32'd2, 32'(irq_cnt));
    end_test();
  endtask

  initial begin
    clk        = 1'b0;
    RSTn       = 1'b0;
    haddr      = '0;
    hwdata     = '0;
    htrans     = soc_bus_pkg::HTRANS_IDLE;
    hsize      = soc_bus_pkg::HSIZE_WORD;
    hwrite     = 1'b0;
    keys       = '1;
    lfsr_state = 32'h4bc4;
    pass_cnt   = 0;
    fail_cnt   = 0;
    test_errs  = 0;
    irq_cnt    = 0;
    timed_out  = 1'b0;
    test_name  = "";
    repeat (3) @(negedge clk);
    RSTn = 1'b1;
    @(negedge clk);
    reset_test();
    ram_test();
    led_test();
    run_cases();
    uart_test();
    finish_run();
  end

endmodule

/* test/bus_cases.txt */
# op size addr data expected, all hex; op W write, R read, K key level
# size 0 byte, 1 half, 2 word; for K the expected column is the key_irq bits seen
W 2 20000100 11223344 0
W 0 20000101 0000aa00 0
R 2 20000100 0 1122aa44
W 1 20000102 beef0000 0
R 2 20000100 0 beefaa44
W 0 20000103 5a000000 0
R 2 20000100 0 5aefaa44
R 2 00000010 0 0
W 2 70000000 deadbeef 0
R 2 70000000 0 0
W 2 50000000 000000a5 0
R 2 50000000 0 a5
K 0 0 e 1
R 2 50000004 0 1
W 2 50000004 1 0
R 2 50000004 0 0
K 0 0 f 0

/* periph_soc.f */
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/ahb_interconnect.sv
src/ahb_block_ram.sv
src/ahb_gpio.sv
src/ahb_uart.sv
src/periph_soc.sv
test/tb_periph_soc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the periph_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_periph_soc \
  -f periph_soc.f -Mdir obj_dir -o sim_periph_soc > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_periph_soc > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q ">>> FAIL" "$SIM_LOG"; then
  exit 1
fi
exit 0
